//--- all.f
+incdir+src
src/serial_alu_pkg.sv
src/nibble_sequencer.sv
src/operand_store.sv
src/nibble_alu.sv
src/result_assembler.sv
src/serial_alu_top.sv
bench/serial_alu_tb.sv

//--- Makefile
SIM := obj_dir/Vserial_alu_tb
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module serial_alu_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- bench/serial_alu_tb.sv
// Serial ALU testbench
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module serial_alu_tb import serial_alu_pkg::*;;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int TABLE_ROWS   = 12;
    localparam int RANDOM_ROWS  = 24;
    localparam int NUM_ROWS     = TABLE_ROWS + RANDOM_ROWS;
    localparam int DONE_LIMIT   = 16;

    typedef struct packed {
        alu_op_e                op;
        logic [`WORD_WIDTH-1:0] a;
        logic [`WORD_WIDTH-1:0] b;
        logic [`WORD_WIDTH-1:0] res;
        logic                   c;
        logic [3:0]             lat;
        logic [3:0]             poke;
    } row_t;

    logic                   clk;
    logic                   arst_n;
    logic                   start;
    alu_op_e                op;
    logic [`WORD_WIDTH-1:0] a;
    logic [`WORD_WIDTH-1:0] b;
    logic [`WORD_WIDTH-1:0] result;
    logic                   carry;
    logic                   busy;
    logic                   done;

    logic [31:0] lfsr = 32'h8e9c6b06;
    int          error_count = 0;

    // op, a, b, expected result, expected carry, latency, cycle of a stray start (0 = none)
    row_t table_rows [TABLE_ROWS] = '{
        '{ADD, 32'hefff_ffff, 32'h0000_0001, 32'hf000_0000, 1'b0, 4'd8, 4'd0},
        '{SUB, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0, 4'd8, 4'd0},
        '{SUB, 32'h1234_5678, 32'h0000_0678, 32'h1234_5000, 1'b1, 4'd8, 4'd0},
        '{AND, 32'hf0f0_1234, 32'h0ff0_ffff, 32'h00f0_1234, 1'b0, 4'd8, 4'd0},
        '{OR,  32'h1200_0034, 32'h0045_6700, 32'h1245_6734, 1'b0, 4'd8, 4'd0},
        '{XOR, 32'haaaa_5555, 32'hffff_0000, 32'h5555_5555, 1'b0, 4'd8, 4'd0},
        '{SHR, 32'h0600_0000, 32'h0000_0000, 32'h0300_0000, 1'b0, 4'd8, 4'd0},
        '{SHR, 32'h0000_0003, 32'h0000_0000, 32'h0000_0001, 1'b1, 4'd8, 4'd0},
        '{INC, 32'hffff_0fff, 32'h0000_0000, 32'hffff_1000, 1'b0, 4'd4, 4'd0},
        '{INC, 32'h0000_0005, 32'h0000_0000, 32'h0000_0006, 1'b0, 4'd1, 4'd0},
        '{INC, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 1'b1, 4'd8, 4'd0},
        '{ADD, 32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 1'b0, 4'd8, 4'd3}
    };

    serial_alu_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .carry  (carry),
        .busy   (busy),
        .done   (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // word-level model of every opcode
    function automatic void model_op(input alu_op_e m_op, input logic [31:0] ma,
                                     input logic [31:0] mb, output logic [31:0] r,
                                     output logic c, output int lat);
        logic [32:0] wide;
        wide = '0;
        lat  = 8;
        case (m_op)
            ADD: wide = {1'b0, ma} + {1'b0, mb};
            SUB: wide = {1'b0, ma} + {1'b0, ~mb} + 33'd1;
            AND: wide = {1'b0, ma & mb};
            OR:  wide = {1'b0, ma | mb};
            XOR: wide = {1'b0, ma ^ mb};
            SHR: wide = {ma[0], 1'b0, ma[31:1]};
            INC: begin
                wide = {1'b0, ma} + 33'd1;
                // each trailing F nibble passes the carry one step further
                lat = 1;
                while (lat < 8 && ma[4*(lat-1) +: 4] == 4'hf) begin
                    lat++;
                end
            end
            default: wide = '0;
        endcase
        r = wide[31:0];
        c = wide[32];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // one operation; operands are scrambled right after start is taken
    task automatic run_op(input alu_op_e op_in, input logic [31:0] a_in,
                          input logic [31:0] b_in, input int poke_at,
                          output logic [31:0] res, output logic c, output int cycles);
        int n;
        @(posedge clk);
        start <= 1'b1;
        op    <= op_in;
        a     <= a_in;
        b     <= b_in;
        @(posedge clk);
        start <= 1'b0;
        a     <= ~a_in;
        b     <= ~b_in;
        for (n = 1; n <= DONE_LIMIT; n++) begin
            @(posedge clk);
            start <= (n == poke_at);
            if (n == poke_at) begin
                op <= SHR;
            end
            @(negedge clk);
            if (done) begin
                break;
            end
            // still working on the word
            check("busy", 32'(busy), 32'd1);
        end
        if (!done) begin
            $display("done did not arrive within %0d cycles", DONE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "operation never finished");
        end
        cycles = n;
        res    = result;
        c      = carry;
        check("busy", 32'(busy), 32'd0);
        @(negedge clk);
        // single strobe and the outputs hold
        check("done", 32'(done), 32'd0);
        check("busy", 32'(busy), 32'd0);
        check("result", result, res);
    endtask

    initial begin
        #((RESET_CYCLES + NUM_ROWS * 12) * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] got_res;
        logic        got_c;
        int          cycles;
        alu_op_e     r_op;
        logic [31:0] r_a;
        logic [31:0] r_b;
        logic [31:0] exp_res;
        logic        exp_c;
        int          exp_lat;
        logic [31:0] sel;
        int          i;

        clk    = 1'b0;
        arst_n = 1'b0;
        start  = 1'b0;
        op     = ADD;
        a      = '0;
        b      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("busy", 32'(busy), 32'd0);
        check("done", 32'(done), 32'd0);
        check("result", result, 32'd0);
        check("carry", 32'(carry), 32'd0);

        for (i = 0; i < TABLE_ROWS; i++) begin
            run_op(table_rows[i].op, table_rows[i].a, table_rows[i].b,
                   int'(table_rows[i].poke), got_res, got_c, cycles);
            check("result", got_res, table_rows[i].res);
            check("carry", 32'(got_c), 32'(table_rows[i].c));
            check("latency", 32'(cycles), 32'(table_rows[i].lat));
        end

        for (i = 0; i < RANDOM_ROWS; i++) begin
            sel  = take_bits(3) % 32'd7;
            r_op = alu_op_e'(sel[2:0]);
            r_a  = take_bits(32);
            r_b  = take_bits(32);
            // force a run of low F nibbles so INC stops at varied points
            if (r_op == INC) begin
                r_a = r_a | ((32'd1 << (4 * take_bits(3))) - 32'd1);
            end
            model_op(r_op, r_a, r_b, exp_res, exp_c, exp_lat);
            run_op(r_op, r_a, r_b, 0, got_res, got_c, cycles);
            check("result", got_res, exp_res);
            check("carry", 32'(got_c), 32'(exp_c));
            check("latency", 32'(cycles), 32'(exp_lat));
        end

        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src/serial_alu_top.sv
// Nibble-serial ALU top
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module serial_alu_top import serial_alu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  alu_op_e                op,
    input  logic [`WORD_WIDTH-1:0] a,
    input  logic [`WORD_WIDTH-1:0] b,
    output logic [`WORD_WIDTH-1:0] result,
    output logic                   carry,
    output logic                   busy,
    output logic                   done
);

    logic                     load;
    logic                     write;
    logic [`IDX_WIDTH-1:0]    index;
    alu_op_e                  op_q;
    logic                     carry_in;
    logic                     carry_out;
    logic [`NIBBLE_WIDTH-1:0] a_nib;
    logic [`NIBBLE_WIDTH-1:0] b_nib;
    logic [`NIBBLE_WIDTH-1:0] res_nib;

    nibble_sequencer seq0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .op        (op),
        .carry_out (carry_out),
        .load      (load),
        .write     (write),
        .index     (index),
        .op_q      (op_q),
        .carry_in  (carry_in),
        .carry     (carry),
        .busy      (busy),
        .done      (done)
    );

    operand_store opnd0 (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .a      (a),
        .b      (b),
        .index  (index),
        .a_nib  (a_nib),
        .b_nib  (b_nib)
    );

    nibble_alu alu0 (
        .op        (op_q),
        .a_nib     (a_nib),
        .b_nib     (b_nib),
        .carry_in  (carry_in),
        .res_nib   (res_nib),
        .carry_out (carry_out)
    );

    result_assembler res0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load),
        .a       (a),
        .write   (write),
        .index   (index),
        .res_nib (res_nib),
        .result  (result)
    );

endmodule

//--- src/result_assembler.sv
// Result assembler
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module result_assembler (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     load,
    input  logic [`WORD_WIDTH-1:0]   a,
    input  logic                     write,
    input  logic [`IDX_WIDTH-1:0]    index,
    input  logic [`NIBBLE_WIDTH-1:0] res_nib,
    output logic [`WORD_WIDTH-1:0]   result
);

    localparam logic [`WORD_WIDTH-1:0] NIB_MASK = `WORD_WIDTH'({`NIBBLE_WIDTH{1'b1}});

    logic [`WORD_WIDTH-1:0] res_wide;

    // current word with one slice replaced, one candidate per index
    logic [`WORD_WIDTH-1:0] inserted [`NIBBLE_COUNT];

    assign res_wide = `WORD_WIDTH'(res_nib);

    for (genvar i = 0; i < `NIBBLE_COUNT; i++) begin : g_insert
        assign inserted[i] = (result & ~(NIB_MASK << (i * `NIBBLE_WIDTH)))
                           | (res_wide << (i * `NIBBLE_WIDTH));
    end

    // preloading a keeps the upper nibbles that an early INC skips
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (load) begin
            result <= a;
        end else if (write) begin
            result <= inserted[index];
        end
    end

    a_load_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(load && write)
    ) else $error("result_assembler: load and write in the same cycle");

endmodule

//--- src/nibble_alu.sv
// Four-bit ALU slice
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module nibble_alu import serial_alu_pkg::*; (
    input  alu_op_e                  op,
    input  logic [`NIBBLE_WIDTH-1:0] a_nib,
    input  logic [`NIBBLE_WIDTH-1:0] b_nib,
    input  logic                     carry_in,
    output logic [`NIBBLE_WIDTH-1:0] res_nib,
    output logic                     carry_out
);

    logic [`NIBBLE_WIDTH-1:0] addend;
    logic [`NIBBLE_WIDTH:0]   sum;

    // one adder serves ADD, SUB and INC
    always_comb begin
        case (op)
            ADD:     addend = b_nib;
            SUB:     addend = ~b_nib;
            default: addend = '0;
        endcase
        sum = {1'b0, a_nib} + {1'b0, addend} + {{`NIBBLE_WIDTH{1'b0}}, carry_in};
    end

    always_comb begin
        case (op)
            ADD, SUB, INC: begin
                res_nib   = sum[`NIBBLE_WIDTH-1:0];
                carry_out = sum[`NIBBLE_WIDTH];
            end
            AND: begin
                res_nib   = a_nib & b_nib;
                carry_out = 1'b0;
            end
            OR: begin
                res_nib   = a_nib | b_nib;
                carry_out = 1'b0;
            end
            XOR: begin
                res_nib   = a_nib ^ b_nib;
                carry_out = 1'b0;
            end
            SHR: begin
                // bit from the nibble above enters at the top
                res_nib   = {carry_in, a_nib[`NIBBLE_WIDTH-1:1]};
                carry_out = a_nib[0];
            end
            default: begin
                res_nib   = '0;
                carry_out = 1'b0;
            end
        endcase
    end

    always_comb begin
        if (!$isunknown(op)) begin
            assert (op inside {ADD, SUB, AND, OR, XOR, SHR, INC})
                else $error("nibble_alu: undefined opcode %0d", op);
        end
    end

endmodule

//--- src/operand_store.sv
// Operand store
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module operand_store (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     load,
    input  logic [`WORD_WIDTH-1:0]   a,
    input  logic [`WORD_WIDTH-1:0]   b,
    input  logic [`IDX_WIDTH-1:0]    index,
    output logic [`NIBBLE_WIDTH-1:0] a_nib,
    output logic [`NIBBLE_WIDTH-1:0] b_nib
);

    logic [`WORD_WIDTH-1:0] a_q;
    logic [`WORD_WIDTH-1:0] b_q;

    // per-slice views of the stored words
    logic [`NIBBLE_WIDTH-1:0] a_slice [`NIBBLE_COUNT];
    logic [`NIBBLE_WIDTH-1:0] b_slice [`NIBBLE_COUNT];

    // operands stay put for the whole operation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (load) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // slice boundaries fixed at elaboration, so selection is a plain index
    for (genvar i = 0; i < `NIBBLE_COUNT; i++) begin : g_slice
        assign a_slice[i] = a_q[i*`NIBBLE_WIDTH +: `NIBBLE_WIDTH];
        assign b_slice[i] = b_q[i*`NIBBLE_WIDTH +: `NIBBLE_WIDTH];
    end

    assign a_nib = a_slice[index];
    assign b_nib = b_slice[index];

endmodule

//--- src/nibble_sequencer.sv
// Nibble sequencer
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module nibble_sequencer import serial_alu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  alu_op_e               op,
    input  logic                  carry_out,
    output logic                  load,
    output logic                  write,
    output logic [`IDX_WIDTH-1:0] index,
    output alu_op_e               op_q,
    output logic                  carry_in,
    output logic                  carry,
    output logic                  busy,
    output logic                  done
);

    seq_state_e state;

    // shift walks from the top nibble down, everything else walks up
    logic dir_down;
    logic last_step;
    logic finish;

    assign load  = start && (state == IDLE);
    assign write = (state == RUN);
    assign busy  = (state == RUN);

    assign last_step = dir_down ? (index == '0)
                                : (index == `IDX_WIDTH'(`NIBBLE_COUNT - 1));

    // INC can stop once no carry is left to propagate
    assign finish = write && (last_step || (op_q == INC && !carry_out));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            index    <= '0;
            dir_down <= 1'b0;
            op_q     <= ADD;
            carry_in <= 1'b0;
            carry    <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (load) begin
                        state    <= RUN;
                        op_q     <= op;
                        dir_down <= (op == SHR);
                        index    <= (op == SHR) ? `IDX_WIDTH'(`NIBBLE_COUNT - 1) : '0;
                        // SUB adds the inverted operand plus one
                        carry_in <= (op == SUB) || (op == INC);
                    end
                end
                RUN: begin
                    carry_in <= carry_out;
                    index    <= dir_down ? index - 1'b1 : index + 1'b1;
                    if (finish) begin
                        state <= IDLE;
                        carry <= carry_out;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // done is a single-cycle strobe
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    ) else $error("nibble_sequencer: done high for two cycles");

    // the strobe only follows the last step of an operation
    a_done_from_run: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> $past(state == RUN)
    ) else $error("nibble_sequencer: done raised outside RUN");

    // a start that arrives while busy leaves the running operation alone
    a_start_ignored: assert property (
        @(posedge clk) disable iff (!arst_n)
        start && busy |=> $stable(op_q) && $stable(dir_down)
    ) else $error("nibble_sequencer: start taken while busy");

endmodule

//--- src/serial_alu_pkg.sv
// Serial ALU types
package serial_alu_pkg;

    // value 7 is left unused on purpose
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SHR = 3'd5,
        INC = 3'd6
    } alu_op_e;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } seq_state_e;

endpackage

//--- src/serial_alu_consts.svh
// Serial ALU width constants
`ifndef SERIAL_ALU_CONSTS_SVH
`define SERIAL_ALU_CONSTS_SVH

// operand and result width
`define WORD_WIDTH 32

// width of one ALU slice
`define NIBBLE_WIDTH 4

// slices per word
`define NIBBLE_COUNT 8

// enough bits to address every slice of a word
`define IDX_WIDTH 3

`endif
